/* design/pixel_pkg.sv */
package pixel_pkg;

    // camera FIFO sizing
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    // released pixel pairs per rate tick
    localparam int TICK_PIXELS = 16;
    localparam int TICK_CW     = $clog2(TICK_PIXELS);

    // colour fields of one RGB565 pixel, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // the packer builds the raw word, the display reads the fields
    typedef union packed {
        logic [15:0] raw;
        rgb565_t     fields;
    } pixel_565_u;

    // one assembled pixel, valid for a single cycle
    typedef struct packed {
        logic       valid;
        pixel_565_u pixel;
    } cam_pixel_t;

    // raw camera byte port
    typedef struct packed {
        logic       href;
        logic       strobe;
        logic [7:0] data;
    } cam_bytes_t;

endpackage

/* design/video_timing_pkg.sv */
package video_timing_pkg;

    // horizontal timing in pixel clocks
    localparam int H_ACTIVE = 16;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 2;
    localparam int H_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // vertical timing in lines
    localparam int V_ACTIVE = 4;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 1;
    localparam int V_BACK   = 1;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // counter widths
    localparam int H_CW = $clog2(H_TOTAL);
    localparam int V_CW = $clog2(V_TOTAL);

    // both syncs active high
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } video_sync_t;

endpackage

/* design/cam_byte_packer.sv */
`timescale 1ns/1ns

module cam_byte_packer (
    input  logic                   clk,
    input  logic                   reset,
    input  pixel_pkg::cam_bytes_t  cam,
    output pixel_pkg::cam_pixel_t  pixel_out
);

    logic                   accept;
    logic                   low_phase;
    logic [7:0]             high_byte;
    logic                   valid_q;
    pixel_pkg::pixel_565_u  pix_q;

    // a byte counts only inside the line
    assign accept = cam.href && cam.strobe;

    // byte phase and output strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            low_phase <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (!cam.href) begin
                // end of line drops any half pixel
                low_phase <= 1'b0;
            end else if (accept) begin
                low_phase <= !low_phase;
                valid_q   <= low_phase;
            end
        end
    end

    // high byte hold and assembled word
    always_ff @(posedge clk) begin
        if (accept) begin
            if (!low_phase) begin
                high_byte <= cam.data;
            end else begin
                pix_q.raw <= {high_byte, cam.data};
            end
        end
    end

    assign pixel_out = '{valid: valid_q, pixel: pix_q};

endmodule

/* design/pixel_combine.sv */
`timescale 1ns/1ns

module pixel_combine (
    input  logic                   clk,
    input  logic                   reset,
    input  pixel_pkg::cam_pixel_t  pixel_1,
    input  pixel_pkg::cam_pixel_t  pixel_2,
    input  logic                   de_next,
    output pixel_pkg::pixel_565_u  pix_out_1,
    output pixel_pkg::pixel_565_u  pix_out_2,
    output logic                   pair_valid,
    output logic                   error
);

    pixel_pkg::cam_pixel_t  pix_in [2];
    pixel_pkg::pixel_565_u  head [2];
    logic [1:0]             not_empty;
    logic [1:0]             overflow;
    logic                   pop;

    assign pix_in[0] = pixel_1;
    assign pix_in[1] = pixel_2;

    // both cameras leave together or not at all
    assign pop = de_next && (&not_empty);

    for (genvar i = 0; i < 2; i++) begin : g_fifo
        pixel_pkg::pixel_565_u          mem [pixel_pkg::FIFO_DEPTH];
        logic [pixel_pkg::FIFO_AW-1:0]  wr_ptr;
        logic [pixel_pkg::FIFO_AW-1:0]  rd_ptr;
        logic [pixel_pkg::FIFO_AW:0]    count;
        logic                           full;
        logic                           push;

        assign full = count == (pixel_pkg::FIFO_AW + 1)'(pixel_pkg::FIFO_DEPTH);
        assign push = pix_in[i].valid && !full;

        assign not_empty[i] = count != '0;
        assign overflow[i]  = pix_in[i].valid && full;
        assign head[i]      = mem[rd_ptr];

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= pix_in[i].pixel;
            end
        end

        // pointers wrap on their own since the depth is a power of two
        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    // pair output, black when either camera is short
    always_ff @(posedge clk) begin
        if (pop) begin
            pix_out_1 <= head[0];
            pix_out_2 <= head[1];
        end else begin
            pix_out_1 <= '0;
            pix_out_2 <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pair_valid <= 1'b0;
            error      <= 1'b0;
        end else begin
            pair_valid <= pop;
            // sticky until reset
            if (|overflow) begin
                error <= 1'b1;
            end
        end
    end

endmodule

/* design/video_timing_gen.sv */
`timescale 1ns/1ns

module video_timing_gen (
    input  logic                          clk,
    input  logic                          reset,
    output video_timing_pkg::video_sync_t sync,
    output logic                          de_next
);

    logic [video_timing_pkg::H_CW-1:0]  h_cnt;
    logic [video_timing_pkg::V_CW-1:0]  v_cnt;
    logic                               h_end;
    logic                               v_end;
    video_timing_pkg::video_sync_t      sync_d;

    assign h_end = h_cnt == video_timing_pkg::H_CW'(video_timing_pkg::H_TOTAL - 1);
    assign v_end = v_cnt == video_timing_pkg::V_CW'(video_timing_pkg::V_TOTAL - 1);

    // frame scan, active area first
    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_end) begin
            h_cnt <= '0;
            v_cnt <= v_end ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // decode of the current count
    assign de_next = (h_cnt < video_timing_pkg::H_CW'(video_timing_pkg::H_ACTIVE))
                  && (v_cnt < video_timing_pkg::V_CW'(video_timing_pkg::V_ACTIVE));

    assign sync_d.de    = de_next;
    assign sync_d.hsync =
        (h_cnt >= video_timing_pkg::H_CW'(video_timing_pkg::H_ACTIVE
                                          + video_timing_pkg::H_FRONT))
        && (h_cnt < video_timing_pkg::H_CW'(video_timing_pkg::H_ACTIVE
                                            + video_timing_pkg::H_FRONT
                                            + video_timing_pkg::H_SYNC));
    // vsync spans whole lines
    assign sync_d.vsync =
        (v_cnt >= video_timing_pkg::V_CW'(video_timing_pkg::V_ACTIVE
                                          + video_timing_pkg::V_FRONT))
        && (v_cnt < video_timing_pkg::V_CW'(video_timing_pkg::V_ACTIVE
                                            + video_timing_pkg::V_FRONT
                                            + video_timing_pkg::V_SYNC));

    always_ff @(posedge clk) begin
        if (reset) begin
            sync <= '0;
        end else begin
            sync <= sync_d;
        end
    end

endmodule

/* design/pixel_rate_tick.sv */
`timescale 1ns/1ns

module pixel_rate_tick (
    input  logic clk,
    input  logic reset,
    input  logic trig,
    output logic tick
);

    logic [pixel_pkg::TICK_CW-1:0] cnt;
    logic                          wrap;

    assign wrap = cnt == pixel_pkg::TICK_CW'(pixel_pkg::TICK_PIXELS - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= trig && wrap;
            if (trig) begin
                cnt <= wrap ? '0 : cnt + 1'b1;
            end
        end
    end

endmodule

/* design/aim_bot_top.sv */
`timescale 1ns/1ns

module aim_bot_top (
    input  logic                          clk,
    input  logic                          reset,
    input  pixel_pkg::cam_bytes_t         cam1,
    input  pixel_pkg::cam_bytes_t         cam2,
    output video_timing_pkg::video_sync_t hdmi_sync,
    output logic [7:0]                    hdmi_r,
    output logic [7:0]                    hdmi_g,
    output logic [7:0]                    hdmi_b,
    output logic                          buf_tick,
    output logic                          comb_err
);

    pixel_pkg::cam_pixel_t  cam1_pixel;
    pixel_pkg::cam_pixel_t  cam2_pixel;
    pixel_pkg::pixel_565_u  comb_pix_1;
    logic                   comb_valid;
    logic                   de_next;

    cam_byte_packer u_cam1_packer (
        .clk       (clk       ),
        .reset     (reset     ),
        .cam       (cam1      ),
        .pixel_out (cam1_pixel)
    );

    cam_byte_packer u_cam2_packer (
        .clk       (clk       ),
        .reset     (reset     ),
        .cam       (cam2      ),
        .pixel_out (cam2_pixel)
    );

    // camera 2 only paces the release, it is not shown
    pixel_combine u_pixel_combine (
        .clk        (clk       ),
        .reset      (reset     ),
        .pixel_1    (cam1_pixel),
        .pixel_2    (cam2_pixel),
        .de_next    (de_next   ),
        .pix_out_1  (comb_pix_1),
        .pix_out_2  (          ),
        .pair_valid (comb_valid),
        .error      (comb_err  )
    );

    video_timing_gen u_video_timing_gen (
        .clk     (clk      ),
        .reset   (reset    ),
        .sync    (hdmi_sync),
        .de_next (de_next  )
    );

    pixel_rate_tick u_buf_tick (
        .clk   (clk       ),
        .reset (reset     ),
        .trig  (comb_valid),
        .tick  (buf_tick  )
    );

    // RGB565 to RGB888 with zero fill
    assign hdmi_r = comb_valid ? {comb_pix_1.fields.red,   3'b000} : 8'h00;
    assign hdmi_g = comb_valid ? {comb_pix_1.fields.green, 2'b00}  : 8'h00;
    assign hdmi_b = comb_valid ? {comb_pix_1.fields.blue,  3'b000} : 8'h00;

endmodule

/* test/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset released just after an edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* test/aim_bot_tb.sv */
`timescale 1ns/1ns

module aim_bot_tb;

    localparam int          NUM_TESTS       = 6;
    localparam int          RESET_CYCLES    = 5;
    localparam int          DRIVE_DELAY     = 1;
    localparam int          WATCHDOG_MARGIN = 1000;
    localparam logic [31:0] SEED            = 32'he088_6e43;
    localparam int FRAME = video_timing_pkg::H_TOTAL * video_timing_pkg::V_TOTAL;
    localparam int DE_PER_FRAME = video_timing_pkg::H_ACTIVE * video_timing_pkg::V_ACTIVE;
    localparam int HS_PER_FRAME = video_timing_pkg::H_SYNC * video_timing_pkg::V_TOTAL;
    localparam int VS_PER_FRAME = video_timing_pkg::H_TOTAL * video_timing_pkg::V_SYNC;

    // pixels per camera, cycles per byte, half pixel, late camera 2, expected error
    typedef struct packed {
        logic [7:0] count;
        logic [3:0] spacing;
        logic       half;
        logic       starve;
        logic       exp_err;
    } test_entry_t;

    test_entry_t tests [NUM_TESTS] = '{
        '{8'd24, 4'd1, 1'b0, 1'b0, 1'b0},
        '{8'd16, 4'd3, 1'b0, 1'b0, 1'b0},
        '{8'd20, 4'd2, 1'b1, 1'b0, 1'b0},
        '{8'd8,  4'd1, 1'b0, 1'b1, 1'b0},
        '{8'd12, 4'd1, 1'b0, 1'b1, 1'b1},
        '{8'd40, 4'd1, 1'b0, 1'b0, 1'b0}
    };
    string names [NUM_TESTS] = '{"assembly", "slow_strobe", "half_pixel",
                                 "starve_cam2", "overflow", "rate_tick"};

    logic                          clk;
    logic                          por_reset;
    logic                          test_reset;
    logic                          dut_reset;
    pixel_pkg::cam_bytes_t         cam1;
    pixel_pkg::cam_bytes_t         cam2;
    video_timing_pkg::video_sync_t hdmi_sync;
    logic [7:0]                    hdmi_r;
    logic [7:0]                    hdmi_g;
    logic [7:0]                    hdmi_b;
    logic                          buf_tick;
    logic                          comb_err;

    // expected pixels in send order
    logic [15:0] cam1_q [$];
    logic [15:0] cam2_q [$];
    string       cur_name;
    int          mon_errs = 0;
    int          cyc_cnt;
    int          de_cnt;
    int          hs_cnt;
    int          vs_cnt;
    int          pair_cnt;
    int          tick_cnt;
    logic        err_seen;

    assign dut_reset = por_reset | test_reset;

    clock_gen u_clock_gen (
        .clk   (clk      ),
        .reset (por_reset)
    );

    aim_bot_top aim_bot_top_inst (
        .clk       (clk      ),
        .reset     (dut_reset),
        .cam1      (cam1     ),
        .cam2      (cam2     ),
        .hdmi_sync (hdmi_sync),
        .hdmi_r    (hdmi_r   ),
        .hdmi_g    (hdmi_g   ),
        .hdmi_b    (hdmi_b   ),
        .buf_tick  (buf_tick ),
        .comb_err  (comb_err )
    );

    function automatic logic [23:0] expand_565(input logic [15:0] px);
        // each field moves to the top of its byte, low bits zero
        return {px[15:11], 3'b000, px[10:5], 2'b00, px[4:0], 3'b000};
    endfunction

    // black is kept for cycles without a pair
    function automatic logic [15:0] random_pixel();
        return 16'(($urandom % 32'hffff) + 32'd1);
    endfunction

    task automatic report_mismatch(input string what, input int exp_val, input int act_val);
        $display("** Error [%s] %s: expected %0d, actual %0d", cur_name, what, exp_val, act_val);
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic send_byte(input logic [7:0] b1, input logic [7:0] b2, input int spacing);
        cam1.strobe = cam1.href;
        cam1.data   = b1;
        cam2.strobe = cam2.href;
        cam2.data   = b2;
        step();
        cam1.strobe = 1'b0;
        cam2.strobe = 1'b0;
        repeat (spacing - 1) step();
    endtask

    task automatic send_pixels(input int n, input int spacing, input logic half,
                               input logic use1, input logic use2);
        logic [15:0] v1;
        logic [15:0] v2;
        cam1.href = use1;
        cam2.href = use2;
        for (int k = 0; k < n; k++) begin
            if (half && k == n / 2) begin
                // lone byte, then a line end throws it away
                send_byte(8'ha5, 8'h5a, spacing);
                cam1.href = 1'b0;
                cam2.href = 1'b0;
                step();
                cam1.href = use1;
                cam2.href = use2;
            end
            v1 = random_pixel();
            v2 = random_pixel();
            if (use1) begin
                cam1_q.push_back(v1);
            end
            if (use2) begin
                cam2_q.push_back(v2);
            end
            send_byte(v1[15:8], v2[15:8], spacing);
            send_byte(v1[7:0], v2[7:0], spacing);
        end
        cam1.href = 1'b0;
        cam2.href = 1'b0;
    endtask

    task automatic run_test(input int t, output int errs);
        test_entry_t e;
        int          mon_base;
        int          frames;
        e          = tests[t];
        errs       = 0;
        mon_base   = mon_errs;
        cur_name   = names[t];
        cam1_q.delete();
        cam2_q.delete();
        test_reset = 1'b1;
        repeat (RESET_CYCLES) step();
        test_reset = 1'b0;
        if (e.starve) begin
            // camera 2 stays silent for a whole frame
            send_pixels(int'(e.count), int'(e.spacing), e.half, 1'b1, 1'b0);
            repeat (FRAME) step();
            if (!e.exp_err) begin
                send_pixels(int'(e.count), int'(e.spacing), e.half, 1'b0, 1'b1);
            end
        end else begin
            send_pixels(int'(e.count), int'(e.spacing), e.half, 1'b1, 1'b1);
        end
        if (e.exp_err) begin
            while (!comb_err) begin
                step();
            end
        end else begin
            while (cam1_q.size() != 0) begin
                step();
            end
        end
        // stop on a frame boundary so the sync counts span whole frames
        do begin
            @(posedge clk);
        end while (cyc_cnt % FRAME != 0);
        #DRIVE_DELAY;
        frames = cyc_cnt / FRAME;
        if (de_cnt != frames * DE_PER_FRAME) begin
            report_mismatch("de cycles", frames * DE_PER_FRAME, de_cnt);
            errs++;
        end
        if (hs_cnt != frames * HS_PER_FRAME) begin
            report_mismatch("hsync cycles", frames * HS_PER_FRAME, hs_cnt);
            errs++;
        end
        if (vs_cnt != frames * VS_PER_FRAME) begin
            report_mismatch("vsync cycles", frames * VS_PER_FRAME, vs_cnt);
            errs++;
        end
        if (pair_cnt != (e.exp_err ? 0 : int'(e.count))) begin
            report_mismatch("released pairs", e.exp_err ? 0 : int'(e.count), pair_cnt);
            errs++;
        end
        if (tick_cnt != pair_cnt / pixel_pkg::TICK_PIXELS) begin
            report_mismatch("rate ticks", pair_cnt / pixel_pkg::TICK_PIXELS, tick_cnt);
            errs++;
        end
        if (comb_err != e.exp_err) begin
            report_mismatch("error flag", int'(e.exp_err), int'(comb_err));
            errs++;
        end
        errs += mon_errs - mon_base;
        if (errs == 0) begin
            $display("PASS  %s", cur_name);
        end else begin
            $display("FAIL  %s, %0d errors", cur_name, errs);
        end
    endtask

    // output side, sampled away from the drive edge
    always @(negedge clk) begin : monitor
        logic [23:0] rgb;
        logic [15:0] px;
        rgb = {hdmi_r, hdmi_g, hdmi_b};
        if (dut_reset) begin
            cyc_cnt  = 0;
            de_cnt   = 0;
            hs_cnt   = 0;
            vs_cnt   = 0;
            pair_cnt = 0;
            tick_cnt = 0;
            err_seen = 1'b0;
        end else begin
            cyc_cnt++;
            de_cnt   += int'(hdmi_sync.de);
            hs_cnt   += int'(hdmi_sync.hsync);
            vs_cnt   += int'(hdmi_sync.vsync);
            tick_cnt += int'(buf_tick);
            if (comb_err) begin
                err_seen = 1'b1;
            end else if (err_seen) begin
                $display("[%s] error flag cleared without a reset", cur_name);
                mon_errs++;
            end
            if (rgb != 24'h0) begin
                if (!hdmi_sync.de) begin
                    $display("[%s] RGB output nonzero outside data enable", cur_name);
                    mon_errs++;
                end else if (cam1_q.size() == 0) begin
                    $display("[%s] a pixel came out with no camera 1 pixel pending", cur_name);
                    mon_errs++;
                end else if (cam2_q.size() == 0) begin
                    $display("[%s] a pair came out before camera 2 sent a pixel", cur_name);
                    mon_errs++;
                end else begin
                    px = cam1_q.pop_front();
                    void'(cam2_q.pop_front());
                    pair_cnt++;
                    if (rgb != expand_565(px)) begin
                        $display("** Error [%s] rgb: expected %06h, actual %06h",
                                 cur_name, expand_565(px), rgb);
                        mon_errs++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int total;
        int limit;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += int'(tests[t].count);
        end
        limit = total * video_timing_pkg::H_TOTAL * 4 + WATCHDOG_MARGIN;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, a test stopped making progress", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        int passed;
        int failed;
        int errs;
        passed     = 0;
        failed     = 0;
        cam1       = '0;
        cam2       = '0;
        test_reset = 1'b1;
        void'($urandom(SEED));
        wait (por_reset == 1'b0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t, errs);
            if (errs == 0) begin
                passed++;
            end else begin
                failed++;
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", NUM_TESTS, passed, failed);
        if (failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
design/pixel_pkg.sv
design/video_timing_pkg.sv
design/cam_byte_packer.sv
design/pixel_combine.sv
design/video_timing_gen.sv
design/pixel_rate_tick.sv
design/aim_bot_top.sv
test/clock_gen.sv
test/aim_bot_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns -f build.f --top-module aim_bot_tb \
    -o aim_bot_sim > build.log 2>&1 \
    || { cat build.log; echo "compile step failed"; exit 1; }
./obj_dir/aim_bot_sim > sim.log 2>&1 \
    && cat sim.log \
    || { cat sim.log; echo "simulation ended abnormally"; exit 1; }
grep -q "SOME TESTS FAILED" sim.log && { echo "result: fail"; exit 1; } || echo "result: pass"
